/* verilog.f */
+incdir+include
hw/fetch_pkg.sv
hw/pc_sequencer.sv
hw/fill_beat_counter.sv
hw/line_buffer.sv
hw/fetch_ctrl.sv
hw/fetch_top.sv
dv/fetch_checker.sv
dv/tb_fetch_top.sv

/* dv/tb_fetch_top.sv */
`include "fetch_config.svh"

module tb_fetch_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_SEQ = 200;
    localparam int N_BP  = 200;
    localparam int N_RDR = 150;
    localparam int N_ERR = 40;
    localparam int WATCHDOG_CYCLES = (1 + N_SEQ + N_BP + N_RDR + N_ERR) * 40;

    logic                       aclk = 1'b0;
    logic                       aresetn;
    fetch_pkg::fetch_redirect_t i_redirect;
    logic                       i_group_ready;
    logic                       i_arready = 1'b0;
    fetch_pkg::axi_r_t          i_r = '0;
    logic                       i_rvalid = 1'b0;
    fetch_pkg::fetch_group_t    o_group;
    logic                       o_group_valid;
    fetch_pkg::axi_ar_t         o_ar;
    logic                       o_arvalid;
    logic                       o_rready;
    int                         chk_errors;
    int                         chk_groups;
    int                         chk_requests;
    int                         chk_bus_faults;
    int                         tb_errors = 0;
    int                         test_errors = 0;

    // read slave state
    logic                       burst_on = 1'b0;
    logic [31:0]                burst_addr = '0;
    int                         beat = 0;
    int                         ar_wait = -1;
    logic                       arvalid_q = 1'b0;
    logic                       rready_q = 1'b0;
    logic [31:0]                ar_addr_q = '0;

    always #50 aclk = ~aclk;

    fetch_top dut (.*);

    fetch_checker chk (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .i_redirect    (i_redirect),
        .i_group       (o_group),
        .i_group_valid (o_group_valid),
        .i_group_ready (i_group_ready),
        .i_ar          (o_ar),
        .i_arvalid     (o_arvalid),
        .i_arready     (i_arready),
        .i_r           (i_r),
        .i_rvalid      (i_rvalid),
        .i_rready      (o_rready),
        .o_errors      (chk_errors),
        .o_groups      (chk_groups),
        .o_requests    (chk_requests),
        .o_bus_faults  (chk_bus_faults)
    );

    // memory word at A is A ^ 0x13579BDF, the error window answers SLVERR
    always @(posedge aclk) begin
        #10;
        if (arvalid_q && i_arready) begin
            burst_on   = 1'b1;
            burst_addr = ar_addr_q;
            beat       = 0;
            ar_wait    = -1;
        end
        if (rready_q && i_rvalid) begin
            beat++;
            burst_on = beat < 16;
        end
        arvalid_q = o_arvalid;
        rready_q  = o_rready;
        ar_addr_q = o_ar.addr;
        if (o_arvalid && ar_wait < 0) ar_wait = $urandom % 4;
        i_arready = o_arvalid && ar_wait == 0;
        if (ar_wait > 0) ar_wait--;
        i_rvalid  = burst_on && ($urandom % 4) != 0;
        i_r.id    = '0;
        i_r.data  = (burst_addr + 32'(beat * 4)) ^ 32'h1357_9BDF;
        i_r.resp  = (burst_addr >= 32'h1C00_4000 && burst_addr <= 32'h1C00_40FF) ? 2'b10 : 2'b00;
        i_r.last  = beat == 15;
    end

    task automatic drive_cycle(input fetch_pkg::fetch_redirect_t rd, input logic ready);
        @(posedge aclk);
        #10;
        i_redirect    = rd;
        i_group_ready = ready;
    endtask

    function automatic logic [31:0] random_target();
        logic [31:0] t;
        t = 32'h1C00_0000 + ($urandom % 32'h2000);
        if (($urandom % 6) != 0) t[1:0] = 2'b00;
        return t;
    endfunction

    function automatic fetch_pkg::fetch_redirect_t random_redirect();
        fetch_pkg::fetch_redirect_t rd;
        rd.wb_valid = $urandom % 2;
        rd.ex_valid = $urandom % 2;
        rd.id_valid = !(rd.wb_valid | rd.ex_valid) || ($urandom % 2);
        rd.wb_pc    = random_target();
        rd.ex_pc    = random_target();
        rd.id_pc    = random_target();
        return rd;
    endfunction

    task automatic run_groups(input int count, input int ready_pct, input int redirect_pct);
        fetch_pkg::fetch_redirect_t rd;
        int target;
        target = chk_groups + count;
        while (chk_groups < target) begin
            rd = '0;
            if (($urandom % 100) < redirect_pct) rd = random_redirect();
            drive_cycle(rd, ($urandom % 100) < ready_pct);
        end
    endtask

    task automatic report_value_error(input string name, input int exp, input int act);
        $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
        tb_errors++;
    endtask

    task automatic close_test(input string name);
        int total;
        total = chk_errors + tb_errors;
        $display("test %-12s groups %0d, requests %0d, errors %0d",
                 name, chk_groups, chk_requests, total - test_errors);
        test_errors = total;
    endtask

    initial begin
        fetch_pkg::fetch_redirect_t idle;
        fetch_pkg::fetch_redirect_t rd;
        int faults;
        int reqs;
        void'($urandom(39));
        idle          = '0;
        aresetn       = 1'b0;
        i_redirect    = '0;
        i_group_ready = 1'b0;
        repeat (5) @(posedge aclk);
        #10;
        aresetn = 1'b1;
        if (o_arvalid !== 1'b0) report_value_error("o_arvalid", 0, o_arvalid);
        if (o_group_valid !== 1'b0) report_value_error("o_group_valid", 0, o_group_valid);
        while (chk_requests == 0) drive_cycle(idle, 1'b1);
        close_test("reset");
        run_groups(N_SEQ, 100, 0);
        if (chk_requests != (N_SEQ * 8 + 63) / 64) begin
            report_value_error("read request count", (N_SEQ * 8 + 63) / 64, chk_requests);
        end
        close_test("sequential");
        run_groups(N_BP, 50, 0);
        close_test("backpressure");
        run_groups(N_RDR, 75, 12);
        close_test("redirect");
        rd          = '0;
        rd.wb_valid = 1'b1;
        rd.wb_pc    = 32'h1C00_4000 + 32'(($urandom % 64) * 4);
        faults      = chk_bus_faults;
        drive_cycle(rd, 1'b1);
        while (chk_bus_faults == faults) drive_cycle(idle, 1'b1);
        // the fetch stays silent here until the next redirect
        repeat (20) drive_cycle(idle, 1'b1);
        reqs = chk_requests;
        drive_cycle(rd, 1'b1);
        while (chk_bus_faults == faults + 1) drive_cycle(idle, 1'b1);
        if (chk_requests == reqs) begin
            $display("error: refetching the faulting line issued no read request");
            tb_errors++;
        end
        rd.wb_pc = `FETCH_RESET_PC;
        drive_cycle(rd, 1'b1);
        run_groups(8, 100, 0);
        close_test("bus_error");
        $display("summary: %0d groups, %0d requests, %0d bus faults, %0d errors",
                 chk_groups, chk_requests, chk_bus_faults, chk_errors + tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        $display("watchdog: tests did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* dv/fetch_checker.sv */
`include "fetch_config.svh"

module fetch_checker (
    input  logic                        aclk,
    input  logic                        aresetn,
    input  fetch_pkg::fetch_redirect_t  i_redirect,
    input  fetch_pkg::fetch_group_t     i_group,
    input  logic                        i_group_valid,
    input  logic                        i_group_ready,
    input  fetch_pkg::axi_ar_t          i_ar,
    input  logic                        i_arvalid,
    input  logic                        i_arready,
    input  fetch_pkg::axi_r_t           i_r,
    input  logic                        i_rvalid,
    input  logic                        i_rready,
    output int                          o_errors,
    output int                          o_groups,
    output int                          o_requests,
    output int                          o_bus_faults
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0]             exp_pc;
    logic [31:0]             line_base;
    logic                    line_valid;
    logic                    burst_err;
    logic                    in_fill;
    logic                    halted;
    logic                    group_held;
    logic                    ar_held;
    logic                    arvalid_q;
    fetch_pkg::fetch_group_t last_group;
    fetch_pkg::axi_ar_t      last_ar;

    task automatic report_mismatch(input string name, input logic [159:0] exp,
                                   input logic [159:0] act);
        $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
        o_errors++;
    endtask

    task automatic note_failure(input string what);
        $display("error: %s", what);
        o_errors++;
    endtask

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ 32'h1357_9BDF;
    endfunction

    function automatic logic [31:0] line_of(input logic [31:0] addr);
        return {addr[31:6], 6'b00_0000};
    endfunction

    // model steps at the falling edge, ahead of the rising edge it predicts
    always @(negedge aclk) begin : compare
        logic                  redirect_any;
        logic                  in_window;
        logic [31:0]           pair;
        fetch_pkg::fetch_exc_e exp_exc;
        redirect_any = i_redirect.wb_valid | i_redirect.ex_valid | i_redirect.id_valid;
        if (!aresetn) begin
            exp_pc       = `FETCH_RESET_PC;
            line_valid   = 1'b0;
            in_fill      = 1'b0;
            halted       = 1'b0;
            group_held   = 1'b0;
            ar_held      = 1'b0;
            arvalid_q    = 1'b0;
            o_errors     = 0;
            o_groups     = 0;
            o_requests   = 0;
            o_bus_faults = 0;
        end else begin
            if (redirect_any && i_group_valid) note_failure("group offered during a redirect");
            if (halted && i_group_valid) note_failure("group offered after a fault, no redirect");
            if (group_held && !redirect_any) begin
                if (!i_group_valid) note_failure("group withdrawn before its transfer");
                else if (i_group !== last_group) report_mismatch("o_group", last_group, i_group);
            end
            if (ar_held && (!i_arvalid || i_ar !== last_ar)) begin
                note_failure("read address changed before its handshake");
            end
            // rready from the address handshake through the last beat
            if (i_rready !== in_fill) report_mismatch("o_rready", in_fill, i_rready);
            if (i_arvalid && !arvalid_q) begin
                if (i_ar.addr !== line_of(exp_pc)) begin
                    report_mismatch("o_ar.addr", line_of(exp_pc), i_ar.addr);
                end
                if ({i_ar.id, i_ar.len, i_ar.size, i_ar.burst, i_ar.prot} !==
                    {4'h0, 8'd15, 3'd2, 2'd1, 3'd4}) begin
                    report_mismatch("o_ar.{id,len,size,burst,prot}",
                                    {4'h0, 8'd15, 3'd2, 2'd1, 3'd4},
                                    {i_ar.id, i_ar.len, i_ar.size, i_ar.burst, i_ar.prot});
                end
                if (exp_pc[1:0] != 2'b00) note_failure("read issued for a misaligned pc");
                if (line_valid && line_base == line_of(exp_pc)) begin
                    note_failure("read issued for a line already held");
                end
            end
            if (i_arvalid && i_arready) begin
                o_requests++;
                line_valid = 1'b0;
                line_base  = i_ar.addr;
                burst_err  = 1'b0;
                in_fill    = 1'b1;
            end
            if (i_rvalid && i_rready) begin
                burst_err = burst_err | (i_r.resp != 2'b00);
                if (i_r.last) begin
                    line_valid = !burst_err;
                    in_fill    = 1'b0;
                end
            end
            if (i_group_valid && i_group_ready) begin
                o_groups++;
                pair      = {exp_pc[31:3], 3'b000};
                in_window = exp_pc >= 32'h1C00_4000 && exp_pc <= 32'h1C00_40FF;
                if (exp_pc[1:0] != 2'b00) exp_exc = fetch_pkg::EXC_ADDR_ALIGN;
                else if (in_window) exp_exc = fetch_pkg::EXC_BUS_ERROR;
                else exp_exc = fetch_pkg::EXC_NONE;
                if (i_group.pc !== exp_pc) report_mismatch("o_group.pc", exp_pc, i_group.pc);
                if (i_group.exc !== exp_exc) report_mismatch("o_group.exc", exp_exc, i_group.exc);
                if (i_group.slot0_valid !== !exp_pc[2]) begin
                    report_mismatch("o_group.slot0_valid", !exp_pc[2], i_group.slot0_valid);
                end
                if (exp_exc != fetch_pkg::EXC_NONE) begin
                    if ({i_group.pc_next, i_group.inst0, i_group.inst1} !== {exp_pc, 64'h0}) begin
                        report_mismatch("o_group.{pc_next,inst0,inst1}", {exp_pc, 64'h0},
                                        {i_group.pc_next, i_group.inst0, i_group.inst1});
                    end
                    halted = 1'b1;
                    if (exp_exc == fetch_pkg::EXC_BUS_ERROR) o_bus_faults++;
                end else begin
                    if (!(line_valid && line_base == line_of(exp_pc))) begin
                        note_failure("group delivered from a line that was never read");
                    end
                    if ({i_group.pc_next, i_group.inst0, i_group.inst1} !==
                        {pair + 32'd8, mem_word(pair), mem_word(pair + 32'd4)}) begin
                        report_mismatch("o_group.{pc_next,inst0,inst1}",
                                        {pair + 32'd8, mem_word(pair), mem_word(pair + 32'd4)},
                                        {i_group.pc_next, i_group.inst0, i_group.inst1});
                    end
                    exp_pc = pair + 32'd8;
                end
            end
            // writeback wins over execute, execute over decode
            if (redirect_any) begin
                exp_pc = i_redirect.wb_valid ? i_redirect.wb_pc :
                         i_redirect.ex_valid ? i_redirect.ex_pc : i_redirect.id_pc;
                halted = 1'b0;
            end
            group_held = i_group_valid && !i_group_ready;
            last_group = i_group;
            ar_held    = i_arvalid && !i_arready;
            last_ar    = i_ar;
            arvalid_q  = i_arvalid;
        end
    end

endmodule

/* hw/fetch_top.sv */
`include "fetch_config.svh"

module fetch_top (
    input  logic                        aclk,
    input  logic                        aresetn,
    input  fetch_pkg::fetch_redirect_t  i_redirect,
    input  logic                        i_group_ready,
    input  logic                        i_arready,
    input  fetch_pkg::axi_r_t           i_r,
    input  logic                        i_rvalid,
    output fetch_pkg::fetch_group_t     o_group,
    output logic                        o_group_valid,
    output fetch_pkg::axi_ar_t          o_ar,
    output logic                        o_arvalid,
    output logic                        o_rready
);

    logic [`FETCH_ADDR_W-1:0]   pc;
    logic                       redirect_any;
    logic                       advance;
    logic                       hit;
    logic [`FETCH_DATA_W-1:0]   inst0;
    logic [`FETCH_DATA_W-1:0]   inst1;
    logic                       fill_start;
    logic                       beat;
    logic                       fill_done;
    logic                       fill_err;
    logic [`FETCH_OFFSET_W-3:0] wr_index;

    pc_sequencer u_pc_sequencer (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .i_redirect     (i_redirect),
        .i_advance      (advance),
        .o_pc           (pc),
        .o_redirect_any (redirect_any)
    );

    fetch_ctrl u_fetch_ctrl (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .i_pc           (pc),
        .i_redirect_any (redirect_any),
        .i_hit          (hit),
        .i_inst0        (inst0),
        .i_inst1        (inst1),
        .i_fill_err     (fill_err),
        .i_arready      (i_arready),
        .i_r            (i_r),
        .i_rvalid       (i_rvalid),
        .i_group_ready  (i_group_ready),
        .o_ar           (o_ar),
        .o_arvalid      (o_arvalid),
        .o_rready       (o_rready),
        .o_fill_start   (fill_start),
        .o_beat         (beat),
        .o_fill_done    (fill_done),
        .o_group        (o_group),
        .o_group_valid  (o_group_valid),
        .o_advance      (advance)
    );

    // any response other than OKAY marks the burst bad
    fill_beat_counter u_fill_beat_counter (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_start    (fill_start),
        .i_beat     (beat),
        .i_resp_err (|i_r.resp),
        .o_index    (wr_index),
        .o_err      (fill_err)
    );

    line_buffer u_line_buffer (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .i_pc         (pc),
        .i_fill_start (fill_start),
        .i_wr_en      (beat),
        .i_wr_index   (wr_index),
        .i_wr_data    (i_r.data),
        .i_fill_done  (fill_done),
        .i_fill_err   (fill_err),
        .o_hit        (hit),
        .o_inst0      (inst0),
        .o_inst1      (inst1)
    );

endmodule

/* hw/fetch_ctrl.sv */
`include "fetch_config.svh"

module fetch_ctrl (
    input  logic                        aclk,
    input  logic                        aresetn,
    input  logic [`FETCH_ADDR_W-1:0]    i_pc,
    input  logic                        i_redirect_any,
    input  logic                        i_hit,
    input  logic [`FETCH_DATA_W-1:0]    i_inst0,
    input  logic [`FETCH_DATA_W-1:0]    i_inst1,
    input  logic                        i_fill_err,
    input  logic                        i_arready,
    input  fetch_pkg::axi_r_t           i_r,
    input  logic                        i_rvalid,
    input  logic                        i_group_ready,
    output fetch_pkg::axi_ar_t          o_ar,
    output logic                        o_arvalid,
    output logic                        o_rready,
    output logic                        o_fill_start,
    output logic                        o_beat,
    output logic                        o_fill_done,
    output fetch_pkg::fetch_group_t     o_group,
    output logic                        o_group_valid,
    output logic                        o_advance
);

    fetch_pkg::fetch_state_e  state;
    fetch_pkg::fetch_state_e  state_next;
    logic [`FETCH_ADDR_W-1:0] ar_addr;
    logic                     bus_fault;
    logic                     redirected;
    logic                     misaligned;
    logic                     fault;
    logic                     transfer;

    assign misaligned = |i_pc[1:0];
    assign fault      = misaligned | bus_fault;

    // any redirect drops the group in the same cycle
    assign o_group_valid = (state == fetch_pkg::LOOKUP) & ~i_redirect_any & (fault | i_hit);
    assign transfer      = o_group_valid & i_group_ready;
    assign o_advance     = transfer & ~fault;

    assign o_fill_start = (state == fetch_pkg::LOOKUP) & ~i_redirect_any & ~fault & ~i_hit;
    assign o_arvalid    = (state == fetch_pkg::REQ);
    assign o_rready     = (state == fetch_pkg::FILL);
    assign o_beat       = o_rready & i_rvalid;
    assign o_fill_done  = o_beat & i_r.last;

    always_comb begin
        o_ar.id    = '0;
        o_ar.addr  = ar_addr;
        o_ar.len   = 8'(`FETCH_BURST_LEN);
        o_ar.size  = 3'(`FETCH_BURST_SIZE);
        o_ar.burst = 2'(`FETCH_BURST_INCR);
        o_ar.lock  = '0;
        o_ar.cache = '0;
        o_ar.prot  = 3'(`FETCH_AR_PROT);
    end

    always_comb begin
        o_group.pc          = i_pc;
        o_group.slot0_valid = ~i_pc[2];
        if (fault) begin
            o_group.pc_next = i_pc;
            o_group.inst0   = '0;
            o_group.inst1   = '0;
            o_group.exc     = misaligned ? fetch_pkg::EXC_ADDR_ALIGN : fetch_pkg::EXC_BUS_ERROR;
        end else begin
            o_group.pc_next = {i_pc[`FETCH_ADDR_W-1:3], 3'b000} + `FETCH_ADDR_W'(8);
            o_group.inst0   = i_inst0;
            o_group.inst1   = i_inst1;
            o_group.exc     = fetch_pkg::EXC_NONE;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            fetch_pkg::LOOKUP: begin
                if (transfer & fault) begin
                    state_next = fetch_pkg::HALT;
                end else if (o_fill_start) begin
                    state_next = fetch_pkg::REQ;
                end
            end
            fetch_pkg::REQ:  if (i_arready) state_next = fetch_pkg::FILL;
            fetch_pkg::FILL: if (o_fill_done) state_next = fetch_pkg::LOOKUP;
            fetch_pkg::HALT: if (i_redirect_any) state_next = fetch_pkg::LOOKUP;
            default:         state_next = fetch_pkg::LOOKUP;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state      <= fetch_pkg::LOOKUP;
            bus_fault  <= 1'b0;
            redirected <= 1'b0;
        end else begin
            state <= state_next;
            // an error only reports if the pc still wants this line
            if (o_fill_done) begin
                bus_fault <= i_fill_err & ~redirected & ~i_redirect_any;
            end else if (i_redirect_any | transfer) begin
                bus_fault <= 1'b0;
            end
            if (o_fill_start) begin
                redirected <= 1'b0;
            end else if (i_redirect_any & (o_arvalid | o_rready)) begin
                redirected <= 1'b1;
            end
        end
    end

    // line base held until the address handshake
    always_ff @(posedge aclk) begin
        if (o_fill_start) begin
            ar_addr <= {i_pc[`FETCH_ADDR_W-1:`FETCH_OFFSET_W], {`FETCH_OFFSET_W{1'b0}}};
        end
    end

endmodule

/* hw/line_buffer.sv */
`include "fetch_config.svh"

module line_buffer (
    input  logic                          aclk,
    input  logic                          aresetn,
    input  logic [`FETCH_ADDR_W-1:0]      i_pc,
    input  logic                          i_fill_start,
    input  logic                          i_wr_en,
    input  logic [`FETCH_OFFSET_W-3:0]    i_wr_index,
    input  logic [`FETCH_DATA_W-1:0]      i_wr_data,
    input  logic                          i_fill_done,
    input  logic                          i_fill_err,
    output logic                          o_hit,
    output logic [`FETCH_DATA_W-1:0]      o_inst0,
    output logic [`FETCH_DATA_W-1:0]      o_inst1
);

    localparam int IDX_W = `FETCH_OFFSET_W - 2;

    logic [`FETCH_DATA_W-1:0] words [`FETCH_LINE_WORDS];
    logic [`FETCH_TAG_W-1:0]  tag;
    logic                     valid;
    logic [IDX_W-1:0]         idx0;
    logic [IDX_W-1:0]         idx1;

    always_ff @(posedge aclk) begin
        if (i_wr_en) begin
            words[i_wr_index] <= i_wr_data;
        end
        if (i_fill_start) begin
            tag <= i_pc[`FETCH_ADDR_W-1:`FETCH_OFFSET_W];
        end
    end

    // line goes invalid while it is being overwritten
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            valid <= 1'b0;
        end else if (i_fill_start) begin
            valid <= 1'b0;
        end else if (i_fill_done) begin
            valid <= ~i_fill_err;
        end
    end

    assign o_hit = valid & (tag == i_pc[`FETCH_ADDR_W-1:`FETCH_OFFSET_W]);

    // pair starts at the 8-byte boundary below pc
    assign idx0 = {i_pc[`FETCH_OFFSET_W-1:3], 1'b0};
    assign idx1 = {i_pc[`FETCH_OFFSET_W-1:3], 1'b1};

    assign o_inst0 = words[idx0];
    assign o_inst1 = words[idx1];

endmodule

/* hw/fill_beat_counter.sv */
`include "fetch_config.svh"

module fill_beat_counter (
    input  logic                          aclk,
    input  logic                          aresetn,
    input  logic                          i_start,
    input  logic                          i_beat,
    input  logic                          i_resp_err,
    output logic [`FETCH_OFFSET_W-3:0]    o_index,
    output logic                          o_err
);

    logic err_q;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            o_index <= '0;
            err_q   <= 1'b0;
        end else if (i_start) begin
            o_index <= '0;
            err_q   <= 1'b0;
        end else if (i_beat) begin
            o_index <= o_index + 1'b1;
            err_q   <= err_q | i_resp_err;
        end
    end

    // include the beat in flight so the last beat counts too
    assign o_err = err_q | (i_beat & i_resp_err);

endmodule

/* hw/pc_sequencer.sv */
`include "fetch_config.svh"

module pc_sequencer (
    input  logic                        aclk,
    input  logic                        aresetn,
    input  fetch_pkg::fetch_redirect_t  i_redirect,
    input  logic                        i_advance,
    output logic [`FETCH_ADDR_W-1:0]    o_pc,
    output logic                        o_redirect_any
);

    logic [`FETCH_ADDR_W-1:0] pc_seq;

    assign o_redirect_any = i_redirect.wb_valid |
                            i_redirect.ex_valid |
                            i_redirect.id_valid;

    // next 8-byte pair counted from the pair base
    assign pc_seq = {o_pc[`FETCH_ADDR_W-1:3], 3'b000} + `FETCH_ADDR_W'(8);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            o_pc <= `FETCH_RESET_PC;
        end else if (i_redirect.wb_valid) begin
            o_pc <= i_redirect.wb_pc;
        end else if (i_redirect.ex_valid) begin
            o_pc <= i_redirect.ex_pc;
        end else if (i_redirect.id_valid) begin
            o_pc <= i_redirect.id_pc;
        end else if (i_advance) begin
            o_pc <= pc_seq;
        end
    end

endmodule

/* hw/fetch_pkg.sv */
`include "fetch_config.svh"

package fetch_pkg;

    typedef enum logic [1:0] {
        LOOKUP,
        REQ,
        FILL,
        HALT
    } fetch_state_e;

    typedef enum logic [1:0] {
        EXC_NONE,
        EXC_ADDR_ALIGN,
        EXC_BUS_ERROR
    } fetch_exc_e;

    // writeback has the highest priority, decode the lowest
    typedef struct packed {
        logic                     wb_valid;
        logic [`FETCH_ADDR_W-1:0] wb_pc;
        logic                     ex_valid;
        logic [`FETCH_ADDR_W-1:0] ex_pc;
        logic                     id_valid;
        logic [`FETCH_ADDR_W-1:0] id_pc;
    } fetch_redirect_t;

    typedef struct packed {
        logic [`FETCH_ADDR_W-1:0] pc;
        logic [`FETCH_ADDR_W-1:0] pc_next;
        logic [`FETCH_DATA_W-1:0] inst0;
        logic [`FETCH_DATA_W-1:0] inst1;
        logic                     slot0_valid;
        fetch_exc_e               exc;
    } fetch_group_t;

    typedef struct packed {
        logic [`FETCH_AXI_ID_W-1:0] id;
        logic [`FETCH_ADDR_W-1:0]   addr;
        logic [7:0]                 len;
        logic [2:0]                 size;
        logic [1:0]                 burst;
        logic [1:0]                 lock;
        logic [3:0]                 cache;
        logic [2:0]                 prot;
    } axi_ar_t;

    typedef struct packed {
        logic [`FETCH_AXI_ID_W-1:0] id;
        logic [`FETCH_DATA_W-1:0]   data;
        logic [1:0]                 resp;
        logic                       last;
    } axi_r_t;

endpackage

/* include/fetch_config.svh */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// address and instruction word width
`define FETCH_ADDR_W 32
`define FETCH_DATA_W 32

`define FETCH_RESET_PC 32'h1C00_0000

// one 64-byte line of 16 words
`define FETCH_LINE_WORDS 16
`define FETCH_OFFSET_W 6
`define FETCH_TAG_W (`FETCH_ADDR_W - `FETCH_OFFSET_W)

// instruction read burst
`define FETCH_AXI_ID_W 4
`define FETCH_BURST_LEN 15
`define FETCH_BURST_SIZE 2
`define FETCH_BURST_INCR 1
`define FETCH_AR_PROT 4

`endif
